// ==== common/isa_pkg.sv ====
// Instruction-set definitions for the byte-wide TLCS-900H style core.
// Holds the ALU operation and jump condition encodings, the flag bit
// positions and the opcode byte patterns used by the decoder.
// Import it wherever opcodes, flags or ALU operations are handled.

`default_nettype none

package isa_pkg;

    localparam int REG_W     = 8;        // Data path width
    localparam int REG_COUNT = 8;        // Byte registers in the file

    // Bit positions inside the flag byte
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    // The first eight follow the ooo field of the second ALU byte
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADC  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SBC  = 4'd3,
        ALU_AND  = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_CP   = 4'd7,
        ALU_MOVE = 4'd8,
        ALU_RCF  = 4'd9,
        ALU_SCF  = 4'd10,
        ALU_CCF  = 4'd11,
        ALU_ZCF  = 4'd12,
        ALU_NOP  = 4'd13
    } alu_op_e;

    // JR condition field in the low opcode nibble
    typedef enum logic [3:0] {
        COND_F,   COND_LT,  COND_LE, COND_ULE,
        COND_OV,  COND_MI,  COND_EQ, COND_C,
        COND_T,   COND_GE,  COND_GT, COND_UGT,
        COND_NOV, COND_PL,  COND_NE, COND_NC
    } cond_e;

    // Single-byte opcodes
    localparam logic [7:0] OPC_NOP = 8'h00;
    localparam logic [7:0] OPC_RCF = 8'h10;
    localparam logic [7:0] OPC_SCF = 8'h11;
    localparam logic [7:0] OPC_CCF = 8'h12;
    localparam logic [7:0] OPC_ZCF = 8'h13;

    // Prefixes of the two-byte opcodes
    localparam logic [4:0] OPC_LD_PFX  = 5'b0010_0;   // LD r,#n
    localparam logic [4:0] OPC_SRC_PFX = 5'b1100_1;   // Source register r
    localparam logic [3:0] OPC_JR_PFX  = 4'b0110;     // JR cc,d8

endpackage

`default_nettype wire

// ==== common/bus_pkg.sv ====
// Port records of the core.
// fetch_rsp_t is what program memory returns on the fetch handshake,
// retire_t is the per-instruction result record the core emits.

`default_nettype none

package bus_pkg;

    // Memory side of the four-phase fetch handshake
    typedef struct packed {
        logic       ack;       // High while data is valid
        logic [7:0] data;      // Instruction byte
    } fetch_rsp_t;

    // One record per executed instruction, valid for a single cycle.
    // wr_en, reg_idx and value double as the register file write port.
    typedef struct packed {
        logic       valid;
        logic       wr_en;     // Register written by this instruction
        logic [2:0] reg_idx;
        logic [7:0] value;     // Written byte or zero without a write
        logic [7:0] flags;     // Flag byte after the instruction
    } retire_t;

endpackage

`default_nettype wire

// ==== hw/control/cpu_sequencer.sv ====
// Instruction sequencer.
// Runs the fetch handshake for the opcode and the optional second byte,
// decodes both into datapath controls and spends one EXEC cycle per
// instruction. Unknown opcodes execute as NOP.

`default_nettype none

module cpu_sequencer
    import isa_pkg::*;
    import bus_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  fetch_rsp_t       fetch_rsp,
    input  logic             cond_met,
    output logic             fetch_req,
    output logic             pc_step,
    output logic             pc_load,
    output logic [7:0]       pc_disp,
    output logic [2:0]       rd_a_idx,
    output logic [2:0]       rd_b_idx,
    output alu_op_e          alu_op,
    output logic [REG_W-1:0] imm,
    output logic             use_imm,
    output logic             exec_en,
    output logic [2:0]       dst_idx,
    output cond_e            cond
);

    typedef enum logic [2:0] {
        REQ_OP,
        REL_OP,
        REQ_ARG,
        REL_ARG,
        EXEC,
        RETIRE
    } state_e;

    state_e     state_q;
    state_e     state_nx;
    logic [7:0] op_q;       // Opcode byte
    logic [7:0] arg_q;      // Second byte, when there is one
    logic       is_ld;
    logic       is_alu;
    logic       is_jr;
    logic       alu_form_ok;
    logic       needs_arg;

    // Opcode classes
    assign is_ld       = op_q[7:3] == OPC_LD_PFX;
    assign is_alu      = op_q[7:3] == OPC_SRC_PFX;
    assign is_jr       = op_q[7:4] == OPC_JR_PFX;
    assign alu_form_ok = arg_q[7] && !arg_q[3];     // 1ooo_0RRR
    assign needs_arg   = is_ld || is_alu || is_jr;

    always_comb begin
        state_nx = state_q;
        case (state_q)
            REQ_OP:
                if (fetch_rsp.ack)
                    state_nx = REL_OP;
            REL_OP:
                if (!fetch_rsp.ack)
                    state_nx = needs_arg ? REQ_ARG : EXEC;
            REQ_ARG:
                if (fetch_rsp.ack)
                    state_nx = REL_ARG;
            REL_ARG:
                if (!fetch_rsp.ack)
                    state_nx = EXEC;
            EXEC:    state_nx = RETIRE;
            RETIRE:  state_nx = REQ_OP;
            default: state_nx = REQ_OP;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state_q <= RETIRE;      // Idle with req low, first fetch follows
        else
            state_q <= state_nx;
    end

    // Bytes are taken on the first cycle ack is seen high
    always_ff @(posedge clk) begin
        if (state_q == REQ_OP && fetch_rsp.ack)
            op_q <= fetch_rsp.data;
        if (state_q == REQ_ARG && fetch_rsp.ack)
            arg_q <= fetch_rsp.data;
    end

    // Handshake and program counter control
    assign fetch_req = (state_q == REQ_OP) || (state_q == REQ_ARG);
    assign pc_step   = fetch_req && fetch_rsp.ack;
    assign exec_en   = state_q == EXEC;
    assign pc_load   = exec_en && is_jr && cond_met;
    assign pc_disp   = arg_q;

    // Datapath steering
    assign rd_a_idx = arg_q[2:0];                    // Destination R as first operand
    assign rd_b_idx = op_q[2:0];                     // Source r
    assign dst_idx  = is_ld ? op_q[2:0] : arg_q[2:0];
    assign imm      = arg_q;
    assign use_imm  = is_ld;
    assign cond     = cond_e'(op_q[3:0]);

    always_comb begin
        alu_op = ALU_NOP;
        case (op_q)
            OPC_NOP: alu_op = ALU_NOP;
            OPC_RCF: alu_op = ALU_RCF;
            OPC_SCF: alu_op = ALU_SCF;
            OPC_CCF: alu_op = ALU_CCF;
            OPC_ZCF: alu_op = ALU_ZCF;
            default: begin
                if (is_ld)
                    alu_op = ALU_MOVE;
                else if (is_alu && alu_form_ok)
                    alu_op = alu_op_e'({1'b0, arg_q[6:4]});  // ooo maps ADD..CP
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/control/pc_counter.sv ====
// Program counter.
// Steps by one for every byte taken from memory and adds the signed
// JR displacement on a taken jump. The displacement is relative to the
// address after the JR instruction, which is where the PC already points.

`default_nettype none

module pc_counter #(
    parameter int ADDR_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pc_step,
    input  logic              pc_load,
    input  logic [7:0]        pc_disp,
    output logic [ADDR_W-1:0] fetch_addr
);

    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] disp_ext;

    assign disp_ext   = {{(ADDR_W - 8){pc_disp[7]}}, pc_disp};  // Sign extend
    assign fetch_addr = pc_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
        end else if (pc_load) begin
            pc_q <= pc_q + disp_ext;
        end else if (pc_step) begin
            pc_q <= pc_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/datapath/reg_file.sv ====
// General register file.
// Eight byte registers with two combinational read ports and one
// write port that updates on the clock edge. Reset clears every register.

`default_nettype none

module reg_file
    import isa_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [2:0]       rd_a_idx,
    input  logic [2:0]       rd_b_idx,
    input  logic             wr_en,
    input  logic [2:0]       wr_idx,
    input  logic [REG_W-1:0] wr_data,
    output logic [REG_W-1:0] rd_a,
    output logic [REG_W-1:0] rd_b
);

    logic [REG_W-1:0] regs [REG_COUNT];

    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/datapath/alu_flags.sv ====
// Byte ALU with the flag register and the JR condition test.
// Results and flags are registered into the retirement record on exec_en;
// that record also feeds the register file write port.

`default_nettype none

module alu_flags
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             exec_en,
    input  alu_op_e          alu_op,
    input  logic [REG_W-1:0] a,
    input  logic [REG_W-1:0] b,
    input  logic [REG_W-1:0] imm,
    input  logic             use_imm,
    input  cond_e            cond,
    input  logic [2:0]       dst_idx,
    output logic             cond_met,
    output retire_t          retire
);

    logic [REG_W-1:0] flags_q;
    logic [REG_W-1:0] flags_nx;
    logic [REG_W-1:0] opnd;
    logic [REG_W-1:0] result;
    logic [REG_W:0]   wide;      // Result with carry or borrow on top
    logic [4:0]       nib;       // Low nibble for H
    logic             cy;        // Carry in for ADC and SBC
    logic             wr_res;
    logic             upd_sz;
    logic             sv;

    assign opnd = use_imm ? imm : b;
    assign cy   = (alu_op == ALU_ADC || alu_op == ALU_SBC) && flags_q[FLAG_C];
    assign sv   = flags_q[FLAG_S] ^ flags_q[FLAG_V];

    always_comb begin
        flags_nx = flags_q;
        result   = '0;
        wide     = '0;
        nib      = '0;
        wr_res   = 1'b0;
        upd_sz   = 1'b0;
        case (alu_op)
            ALU_ADD, ALU_ADC: begin
                wide   = {1'b0, a} + {1'b0, opnd} + {8'd0, cy};
                nib    = {1'b0, a[3:0]} + {1'b0, opnd[3:0]} + {4'd0, cy};
                result = wide[7:0];
                wr_res = 1'b1;
                upd_sz = 1'b1;
                flags_nx[FLAG_C] = wide[8];
                flags_nx[FLAG_H] = nib[4];
                flags_nx[FLAG_V] = (a[7] == opnd[7]) && (result[7] != a[7]);
                flags_nx[FLAG_N] = 1'b0;
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                wide   = {1'b0, a} - {1'b0, opnd} - {8'd0, cy};
                nib    = {1'b0, a[3:0]} - {1'b0, opnd[3:0]} - {4'd0, cy};
                result = wide[7:0];
                wr_res = alu_op != ALU_CP;               // CP only sets flags
                upd_sz = 1'b1;
                flags_nx[FLAG_C] = wide[8];              // Borrow
                flags_nx[FLAG_H] = nib[4];
                flags_nx[FLAG_V] = (a[7] != opnd[7]) && (result[7] != a[7]);
                flags_nx[FLAG_N] = 1'b1;
            end
            ALU_AND, ALU_XOR, ALU_OR: begin
                if (alu_op == ALU_AND)
                    result = a & opnd;
                else if (alu_op == ALU_XOR)
                    result = a ^ opnd;
                else
                    result = a | opnd;
                wr_res = 1'b1;
                upd_sz = 1'b1;
                flags_nx[FLAG_C] = 1'b0;
                flags_nx[FLAG_H] = alu_op == ALU_AND;
                flags_nx[FLAG_V] = ~^result;             // Even parity
                flags_nx[FLAG_N] = 1'b0;
            end
            ALU_MOVE: begin
                result = opnd;
                wr_res = 1'b1;
            end
            ALU_RCF, ALU_SCF: begin
                flags_nx[FLAG_C] = alu_op == ALU_SCF;
                flags_nx[FLAG_H] = 1'b0;
                flags_nx[FLAG_N] = 1'b0;
            end
            ALU_CCF: begin
                flags_nx[FLAG_C] = ~flags_q[FLAG_C];
                flags_nx[FLAG_N] = 1'b0;
            end
            ALU_ZCF: begin
                flags_nx[FLAG_C] = ~flags_q[FLAG_Z];
                flags_nx[FLAG_N] = 1'b0;
            end
            default: ;                                   // NOP and JR
        endcase
        if (upd_sz) begin
            flags_nx[FLAG_S] = result[7];
            flags_nx[FLAG_Z] = result == '0;
        end
    end

    // Condition table against the current flags
    always_comb begin
        case (cond)
            COND_F:   cond_met = 1'b0;
            COND_LT:  cond_met = sv;
            COND_LE:  cond_met = flags_q[FLAG_Z] | sv;
            COND_ULE: cond_met = flags_q[FLAG_Z] | flags_q[FLAG_C];
            COND_OV:  cond_met = flags_q[FLAG_V];
            COND_MI:  cond_met = flags_q[FLAG_S];
            COND_EQ:  cond_met = flags_q[FLAG_Z];
            COND_C:   cond_met = flags_q[FLAG_C];
            COND_T:   cond_met = 1'b1;
            COND_GE:  cond_met = ~sv;
            COND_GT:  cond_met = ~(flags_q[FLAG_Z] | sv);
            COND_UGT: cond_met = ~(flags_q[FLAG_Z] | flags_q[FLAG_C]);
            COND_NOV: cond_met = ~flags_q[FLAG_V];
            COND_PL:  cond_met = ~flags_q[FLAG_S];
            COND_NE:  cond_met = ~flags_q[FLAG_Z];
            default:  cond_met = ~flags_q[FLAG_C];       // NC
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags_q <= '0;
            retire  <= '0;
        end else begin
            retire.valid <= exec_en;                     // One cycle per instruction
            retire.wr_en <= exec_en && wr_res;
            if (exec_en) begin
                flags_q        <= flags_nx;
                retire.reg_idx <= dst_idx;
                retire.value   <= wr_res ? result : '0;
                retire.flags   <= flags_nx;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/cpu_core.sv ====
// Top of the byte-wide CPU core.
// Fetches bytes from program memory over a four-phase req/ack port and
// reports every executed instruction on the retirement port.
// ADDR_W sets the program address width and is passed to the submodules.

`default_nettype none

module cpu_core
    import isa_pkg::*;
    import bus_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    output logic              fetch_req,
    output logic [ADDR_W-1:0] fetch_addr,
    input  fetch_rsp_t        fetch_rsp,
    output retire_t           retire
);

    logic             pc_step;
    logic             pc_load;
    logic [7:0]       pc_disp;
    logic [2:0]       rd_a_idx;
    logic [2:0]       rd_b_idx;
    logic [REG_W-1:0] rd_a;
    logic [REG_W-1:0] rd_b;
    alu_op_e          alu_op;
    logic [REG_W-1:0] imm;
    logic             use_imm;
    logic             exec_en;
    logic [2:0]       dst_idx;
    cond_e            cond;
    logic             cond_met;

    cpu_sequencer #(
        .ADDR_W (ADDR_W)
    ) u_seq (
        .clk       (clk),
        .rst       (rst),
        .fetch_rsp (fetch_rsp),
        .cond_met  (cond_met),
        .fetch_req (fetch_req),
        .pc_step   (pc_step),
        .pc_load   (pc_load),
        .pc_disp   (pc_disp),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .alu_op    (alu_op),
        .imm       (imm),
        .use_imm   (use_imm),
        .exec_en   (exec_en),
        .dst_idx   (dst_idx),
        .cond      (cond)
    );

    pc_counter #(
        .ADDR_W (ADDR_W)
    ) u_pc (
        .clk        (clk),
        .rst        (rst),
        .pc_step    (pc_step),
        .pc_load    (pc_load),
        .pc_disp    (pc_disp),
        .fetch_addr (fetch_addr)
    );

    // Writes come from the registered retirement record
    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .wr_en    (retire.wr_en),
        .wr_idx   (retire.reg_idx),
        .wr_data  (retire.value),
        .rd_a     (rd_a),
        .rd_b     (rd_b)
    );

    alu_flags u_alu (
        .clk      (clk),
        .rst      (rst),
        .exec_en  (exec_en),
        .alu_op   (alu_op),
        .a        (rd_a),
        .b        (rd_b),
        .imm      (imm),
        .use_imm  (use_imm),
        .cond     (cond),
        .dst_idx  (dst_idx),
        .cond_met (cond_met),
        .retire   (retire)
    );

endmodule

`default_nettype wire

// ==== tests/tb_ref_model.svh ====
// Reference model for the core testbench.
// run_model() executes prog[] from address 0 by the instruction rules and
// queues one expected retirement record and one test number per instruction.
// Included inside tb_cpu_core, which owns prog[] and the queues.

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic jump_taken(input logic [7:0] f, input logic [3:0] cc);
    logic lt;
    logic t;
    lt = f[FLAG_S] ^ f[FLAG_V];
    case (cc[2:0])
        3'd0:    t = 1'b0;
        3'd1:    t = lt;
        3'd2:    t = f[FLAG_Z] | lt;
        3'd3:    t = f[FLAG_Z] | f[FLAG_C];
        3'd4:    t = f[FLAG_V];
        3'd5:    t = f[FLAG_S];
        3'd6:    t = f[FLAG_Z];
        default: t = f[FLAG_C];
    endcase
    return cc[3] ? !t : t;                      // Upper eight negate the lower eight
endfunction

function automatic void run_model(input int end_pc);
    logic [7:0] r [8];
    logic [7:0] f;
    logic [7:0] op;
    logic [7:0] arg;
    retire_t    rec;
    int         pc;
    int         ipc;
    int         tid;
    int         k;
    int         o;
    int         x;
    int         y;
    int         sx;
    int         sy;
    int         cin;
    int         res;
    f  = '0;
    pc = 0;
    for (k = 0; k < 8; k++)
        r[k] = '0;
    while (pc < end_pc && exp_q.size() < 2000) begin
        ipc = pc;
        op  = prog[pc];
        arg = prog[pc + 1];
        rec = '0;
        rec.valid = 1'b1;
        pc++;
        if (op[7:3] == 5'b00100) begin          // LD r,#n
            pc++;
            r[op[2:0]]  = arg;
            rec.wr_en   = 1'b1;
            rec.reg_idx = op[2:0];
            rec.value   = arg;
        end else if (op[7:3] == 5'b11001) begin // Register ALU group
            pc++;
            if (arg[7] && !arg[3]) begin
                o   = int'(arg[6:4]);
                x   = int'(r[arg[2:0]]);        // Destination is the first operand
                y   = int'(r[op[2:0]]);
                sx  = x > 127 ? x - 256 : x;
                sy  = y > 127 ? y - 256 : y;
                cin = (o == 1 || o == 3) ? int'(f[FLAG_C]) : 0;
                if (o < 2) begin
                    res = x + y + cin;
                    f[FLAG_C] = res > 255;
                    f[FLAG_H] = (x % 16) + (y % 16) + cin > 15;
                    f[FLAG_V] = (sx + sy + cin > 127) || (sx + sy + cin < -128);
                    f[FLAG_N] = 1'b0;
                end else if (o < 4 || o == 7) begin
                    res = x - y - cin;
                    f[FLAG_C] = res < 0;
                    f[FLAG_H] = (x % 16) < (y % 16) + cin;
                    f[FLAG_V] = (sx - sy - cin > 127) || (sx - sy - cin < -128);
                    f[FLAG_N] = 1'b1;
                end else begin
                    res = (o == 4) ? (x & y) : (o == 5) ? (x ^ y) : (x | y);
                    f[FLAG_C] = 1'b0;
                    f[FLAG_H] = o == 4;
                    f[FLAG_V] = $countones(res) % 2 == 0;
                    f[FLAG_N] = 1'b0;
                end
                res = res & 255;
                f[FLAG_S] = res > 127;
                f[FLAG_Z] = res == 0;
                rec.wr_en   = o != 7;           // CP keeps the register
                rec.reg_idx = rec.wr_en ? arg[2:0] : 3'd0;
                rec.value   = rec.wr_en ? 8'(res) : 8'd0;
                if (rec.wr_en)
                    r[arg[2:0]] = 8'(res);
            end
        end else if (op[7:4] == 4'b0110) begin  // JR cc,d8 from the next address
            pc++;
            if (jump_taken(f, op[3:0]))
                pc = pc + (arg[7] ? int'(arg) - 256 : int'(arg));
        end else if (op == 8'h10 || op == 8'h11) begin
            f[FLAG_C] = op[0];
            f[FLAG_H] = 1'b0;
            f[FLAG_N] = 1'b0;
        end else if (op == 8'h12) begin
            f[FLAG_C] = !f[FLAG_C];
            f[FLAG_N] = 1'b0;
        end else if (op == 8'h13) begin
            f[FLAG_C] = !f[FLAG_Z];
            f[FLAG_N] = 1'b0;
        end
        rec.flags = f;
        tid = 0;
        for (k = 0; k < sect_start.size(); k++)
            if (ipc >= sect_start[k])
                tid = k;
        exp_q.push_back(rec);
        exp_tid.push_back(tid);
    end
endfunction

`endif

// ==== tests/tb_cpu_core.sv ====
// Testbench for the byte-wide CPU core.
// Builds a test program in a byte array, serves it over the fetch
// handshake with random ack delays and compares every retirement record
// with the reference model from tb_ref_model.svh.

`default_nettype none

module tb_cpu_core
    import isa_pkg::*;
    import bus_pkg::*;
();

    localparam int PROG_SIZE = 1024;

    logic       clk = 1'b0;
    logic       rst;
    logic       fetch_req;
    logic [15:0] fetch_addr;
    fetch_rsp_t fetch_rsp;
    retire_t    retire;
    logic [7:0] prog [PROG_SIZE];
    int         plen;
    int         seed;
    logic       started = 1'b0;
    longint     limit_time;
    retire_t    exp_q [$];
    int         exp_tid [$];
    int         sect_start [$];
    string      sect_name [$];
    int         errors;
    int         checks;

    cpu_core #(
        .ADDR_W (16)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_rsp  (fetch_rsp),
        .retire     (retire)
    );

    always #4 clk = ~clk;

    `include "tb_ref_model.svh"

    task automatic put_byte(input logic [7:0] b);
        prog[plen] = b;
        plen++;
    endtask

    task automatic load_imm(input int r, input logic [7:0] n);
        put_byte(8'(8'h20 | r));
        put_byte(n);
    endtask

    // Second byte 1ooo_0RRR with R also the first operand
    task automatic alu_rr(input int op, input int dst, input int src);
        put_byte(8'(8'hC8 | src));
        put_byte(8'(8'h80 | (op << 4) | dst));
    endtask

    task automatic jump_rel(input int cc, input logic [7:0] d);
        put_byte(8'(8'h60 | cc));
        put_byte(d);
    endtask

    task automatic open_test(input string name);
        sect_start.push_back(plen);
        sect_name.push_back(name);
    endtask

    task automatic build_program();
        int i;
        int o;
        plen = 0;
        for (i = 0; i < PROG_SIZE; i++)
            prog[i] = 8'h00;                    // NOP padding
        open_test("load all registers");
        for (i = 0; i < 8; i++)
            load_imm(i, 8'($random(seed)));
        open_test("add and subtract");
        for (i = 0; i < 8; i++) begin
            load_imm(i, 8'($random(seed)));
            load_imm((i + 3) % 8, 8'($random(seed)));
            alu_rr(i % 4, i, (i + 3) % 8);
        end
        open_test("logic and compare");
        for (i = 0; i < 6; i++) begin
            load_imm(0, 8'($random(seed)));
            load_imm(5, 8'($random(seed)));
            alu_rr(4 + i % 4, 0, 5);
        end
        open_test("carry flag operations");
        put_byte(8'h11);
        put_byte(8'h12);
        put_byte(8'h12);
        put_byte(8'h10);
        put_byte(8'h13);
        alu_rr(5, 0, 0);                        // XOR r0,r0 sets Z
        put_byte(8'h13);
        put_byte(8'h12);
        open_test("conditional jumps");
        for (i = 0; i < 16; i++) begin
            load_imm(1, 8'($random(seed)));
            load_imm(2, 8'($random(seed)));
            alu_rr($random(seed) & 7, 1, 2);
            jump_rel(i, 8'd2);                  // Skips the next LD when taken
            load_imm(7, 8'(8'hE0 + i));
            load_imm(6, 8'(i));
        end
        load_imm(4, 8'd3);
        load_imm(3, 8'd1);
        alu_rr(2, 4, 3);
        jump_rel(14, 8'hFC);                    // JR NE back to the SUB
        open_test("random mix under stalls");
        for (i = 0; i < 12; i++) begin
            o = $random(seed) & 3;
            if (o == 0)
                load_imm(i % 8, 8'($random(seed)));
            else if (o == 1)
                alu_rr($random(seed) & 7, $random(seed) & 7, $random(seed) & 7);
            else
                put_byte(8'(8'h10 | ($random(seed) & 3)));
        end
    endtask

    task automatic report_test(input int id, input int n, input int errs);
        if (errs == 0)
            $display("test %0d, %s: %0d records ok", id + 1, sect_name[id], n);
        else
            $display("test %0d, %s: %0d records, %0d wrong", id + 1, sect_name[id], n, errs);
    endtask

    initial begin : stimulus
        rst    = 1'b1;
        seed   = 32'h47aa_92e5;
        errors = 0;
        checks = 0;
        build_program();
        run_model(plen);
        limit_time = (longint'(exp_q.size()) * 64 + 10) * 8;
        repeat (10) @(posedge clk);
        #1;
        checks++;
        assert (!fetch_req && !retire.valid && fetch_addr == '0)
        else begin
            $display("mismatch at %0t: core not idle in reset, req %b valid %b address %h",
                     $time, fetch_req, retire.valid, fetch_addr);
            errors++;
        end
        rst     = 1'b0;
        started = 1'b1;
    end

    // Program memory driving 1 unit after the rising edge
    initial begin : responder
        int gap;
        fetch_rsp = '0;
        wait (started);
        forever begin
            if (fetch_req && !fetch_rsp.ack) begin
                gap = $random(seed) & 3;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                fetch_rsp.data = prog[fetch_addr[9:0]];
                fetch_rsp.ack  = 1'b1;
                while (fetch_req) begin
                    @(posedge clk);
                    #1;
                end
                fetch_rsp.ack = 1'b0;
            end
            @(posedge clk);
            #1;
        end
    end

    initial begin : compare
        retire_t want;
        retire_t got;
        int      tid;
        int      cur;
        int      n;
        int      errs;
        wait (started);
        @(posedge clk);
        #1;
        checks++;
        assert (!retire.valid)
        else begin
            $display("mismatch at %0t: retirement in the first cycle after reset", $time);
            errors++;
        end
        $display("reset: %s", errors == 0 ? "ok" : "failed");
        cur  = 0;
        n    = 0;
        errs = 0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #1;
            if (retire.valid) begin
                want = exp_q.pop_front();
                tid  = exp_tid.pop_front();
                if (tid != cur) begin
                    report_test(cur, n, errs);
                    cur  = tid;
                    n    = 0;
                    errs = 0;
                end
                got = retire;
                n++;
                checks++;
                assert (got.wr_en == want.wr_en && got.value == want.value &&
                        got.flags == want.flags &&
                        (!want.wr_en || got.reg_idx == want.reg_idx))
                else begin
                    $display("mismatch at %0t: %s got wr %b r%0d=%h f=%h, want wr %b r%0d=%h f=%h",
                             $time, sect_name[tid], got.wr_en, got.reg_idx, got.value,
                             got.flags, want.wr_en, want.reg_idx, want.value, want.flags);
                    errs++;
                    errors++;
                end
            end
        end
        report_test(cur, n, errs);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin : watchdog
        wait (started);
        #(limit_time);
        $display("timeout: the core stopped retiring before the end of the program");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tests
common/isa_pkg.sv
common/bus_pkg.sv
hw/control/cpu_sequencer.sv
hw/control/pc_counter.sv
hw/datapath/reg_file.sv
hw/datapath/alu_flags.sv
hw/cpu_core.sv
tests/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_cpu_core -Mdir obj_dir
./obj_dir/Vtb_cpu_core | tee "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
